//--- common/ppfifo_pkg.sv
/* Shared constants and types for the ping-pong packet FIFO.
   Two banks only; word counts are 24 bits and saturate at the bank depth. */
package ppfifo_pkg;

  // Fixed bank arrangement
  parameter int NUM_BANKS = 2;
  parameter int COUNT_WIDTH = 24;

  // Defaults used by the top level
  parameter int DEFAULT_DATA_WIDTH = 8;
  parameter int DEFAULT_ADDRESS_WIDTH = 4;

  // Number of words in a packet
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // Index of one bank
  typedef logic bank_sel_t;

  // One flag per bank, bit i is bank i
  typedef logic [NUM_BANKS-1:0] bank_mask_t;

  // Life of a bank as seen from the write side
  typedef enum logic [1:0] {
    BANK_FREE,
    BANK_FILLING,
    BANK_FULL,
    BANK_READING
  } bank_state_t;

  // Read controller states
  typedef enum logic [2:0] {
    RD_IDLE,
    RD_PREFETCH,
    RD_OFFER,
    RD_ACTIVE,
    RD_RELEASE
  } read_state_t;

endpackage

//--- common/bank_handoff_if.sv
/* Bank status shared by write controller, arbiter and read controller.
   grant_taken and bank_released are single-cycle pulses. */
interface bank_handoff_if (
  input logic write_clock
);
  import ppfifo_pkg::*;

  // Banks holding a packet the reader has not taken yet
  bank_mask_t bank_full;
  // Word count per bank, stable while full or being read
  count_t     bank_count [NUM_BANKS];

  logic       grant_valid;
  bank_sel_t  grant_bank;
  logic       grant_taken;
  bank_mask_t bank_released;

  modport write_side (
    output bank_full, bank_count,
    input  grant_taken, grant_bank, bank_released
  );

  modport arbiter (
    input  bank_full, grant_taken,
    output grant_valid, grant_bank
  );

  modport read_side (
    input  grant_valid, grant_bank, bank_count,
    output grant_taken, bank_released
  );

  // A taken bank is never offered again until the writer refills it
  assert property (@(posedge write_clock)
    grant_taken |=> !(grant_valid && (grant_bank == $past(grant_bank))));

endinterface

//--- ppfifo/ppfifo_write_ctrl.sv
/* Write side of the ping-pong FIFO. Only one write_activate bit may be high;
   strobes past the bank depth are dropped and the count saturates. */
module ppfifo_write_ctrl #(
  parameter int ADDRESS_WIDTH = ppfifo_pkg::DEFAULT_ADDRESS_WIDTH
) (
  input  logic                   write_clock,
  input  logic                   reset,
  input  ppfifo_pkg::bank_mask_t write_activate,
  input  logic                   write_strobe,
  output ppfifo_pkg::bank_mask_t write_ready,
  output logic                   inactive,
  output logic                   ram_write_enable,
  output logic [ADDRESS_WIDTH:0] ram_write_address,
  bank_handoff_if.write_side     handoff
);
  import ppfifo_pkg::*;

  localparam count_t DEPTH = count_t'(1) << ADDRESS_WIDTH;

  bank_state_t              state [NUM_BANKS];
  count_t                   count [NUM_BANKS];
  logic [ADDRESS_WIDTH-1:0] offset;
  // Delays write_ready by one cycle after reset
  logic                     ready_en;
  bank_sel_t                active_bank;
  logic                     writable;

  // Bank 1 only when its bit is set, bank 0 otherwise
  assign active_bank = write_activate[1];

  // Bank must be owned by the writer and not yet at depth
  assign writable = ((state[active_bank] == BANK_FREE) ||
                     (state[active_bank] == BANK_FILLING)) &&
                    (count[active_bank] < DEPTH);

  assign ram_write_enable  = write_strobe && (write_activate != '0) && writable;
  assign ram_write_address = {active_bank, offset};

  assign inactive = (count[0] == '0) && (count[1] == '0) &&
                    (write_ready == 2'b11) && !write_strobe;

  // Status toward the arbiter and reader
  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      handoff.bank_full[i]  = (state[i] == BANK_FULL);
      handoff.bank_count[i] = count[i];
    end
  end

  always_ff @(posedge write_clock) begin
    if (reset) begin
      ready_en    <= 1'b0;
      write_ready <= '0;
      offset      <= '0;
      for (int i = 0; i < NUM_BANKS; i++) begin
        state[i] <= BANK_FREE;
        count[i] <= '0;
      end
    end else begin
      ready_en <= 1'b1;

      // Offset restarts whenever the writer lets go
      if (write_activate == '0)
        offset <= '0;
      else if (ram_write_enable)
        offset <= offset + 1'b1;

      for (int i = 0; i < NUM_BANKS; i++) begin
        case (state[i])
          BANK_FREE:
            if (write_activate[i] && write_strobe)
              state[i] <= BANK_FILLING;
          BANK_FILLING:
            // Count is nonzero here since the first strobe got us in
            if (!write_activate[i])
              state[i] <= BANK_FULL;
          BANK_FULL:
            if (handoff.grant_taken && (handoff.grant_bank == bank_sel_t'(i)))
              state[i] <= BANK_READING;
          BANK_READING:
            if (handoff.bank_released[i])
              state[i] <= BANK_FREE;
          default:
            state[i] <= BANK_FREE;
        endcase

        if (state[i] == BANK_READING && handoff.bank_released[i])
          count[i] <= '0;
        else if (ram_write_enable && (active_bank == bank_sel_t'(i)))
          count[i] <= count[i] + 1'b1;

        // Ready falls after the first strobe, rises as soon as the reader lets go
        if (write_activate[i] && write_strobe)
          write_ready[i] <= 1'b0;
        else if (ready_en && !write_activate[i] &&
                 ((state[i] == BANK_FREE) || handoff.bank_released[i]))
          write_ready[i] <= 1'b1;
      end
    end
  end

  // At most one bank written at a time
  assert property (@(posedge write_clock) disable iff (reset)
    $onehot0(write_activate));

  // Writer only takes banks that were offered as ready
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_activate_check
    assert property (@(posedge write_clock) disable iff (reset)
      $rose(write_activate[b]) |-> write_ready[b]);
  end

endmodule

//--- ppfifo/bank_arbiter.sv
/* Grants full banks to the reader oldest first.
   Assumes banks become full one at a time, as a single writer guarantees. */
module bank_arbiter (
  input logic             write_clock,
  input logic             reset,
  bank_handoff_if.arbiter handoff
);
  import ppfifo_pkg::*;

  // Oldest full bank when both are waiting
  bank_sel_t  order;
  bank_mask_t prev_full;
  bank_mask_t rising;

  assign rising = handoff.bank_full & ~prev_full;

  assign handoff.grant_valid = |handoff.bank_full;
  // With one bank full, name it; with two, fall back on arrival order
  assign handoff.grant_bank  = (handoff.bank_full == 2'b11) ? order :
                               handoff.bank_full[1];

  always_ff @(posedge write_clock) begin
    if (reset) begin
      order     <= 1'b0;
      prev_full <= '0;
    end else begin
      prev_full <= handoff.bank_full;
      if (handoff.grant_taken)
        // Remaining bank, if any, is now the oldest
        order <= ~handoff.grant_bank;
      else if (rising[0] && !handoff.bank_full[1])
        order <= 1'b0;
      else if (rising[1] && !handoff.bank_full[0])
        order <= 1'b1;
    end
  end

  // A waiting grant keeps its bank until the reader takes it
  assert property (@(posedge write_clock) disable iff (reset)
    (handoff.grant_valid && !handoff.grant_taken) |=>
      (handoff.grant_valid && (handoff.grant_bank == $past(handoff.grant_bank))));

endmodule

//--- ppfifo/ppfifo_read_ctrl.sv
/* Read side FSM with first-word-fall-through data from the registered RAM.
   read_strobe is only honoured while read_activate is high. */
module ppfifo_read_ctrl #(
  parameter int DATA_WIDTH    = ppfifo_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDRESS_WIDTH = ppfifo_pkg::DEFAULT_ADDRESS_WIDTH
) (
  input  logic                   write_clock,
  input  logic                   reset,
  input  logic                   read_activate,
  input  logic                   read_strobe,
  output logic                   read_ready,
  output ppfifo_pkg::count_t     read_count,
  output logic [ADDRESS_WIDTH:0] ram_read_address,
  bank_handoff_if.read_side      handoff
);
  import ppfifo_pkg::*;

  // Bank depth must fit in a word count
  if (DATA_WIDTH < 1 || ADDRESS_WIDTH < 1 || ADDRESS_WIDTH >= COUNT_WIDTH) begin : g_param_check
    $error("ppfifo_read_ctrl: unsupported DATA_WIDTH or ADDRESS_WIDTH");
  end

  read_state_t              state;
  bank_sel_t                rd_bank;
  // Offset of the word now on read_data
  logic [ADDRESS_WIDTH-1:0] rd_offset;
  logic [ADDRESS_WIDTH-1:0] next_offset;
  logic                     advance;

  // Step only within the packet, the last word stays put
  assign advance = read_activate && read_strobe &&
                   ((state == RD_OFFER) || (state == RD_ACTIVE)) &&
                   ((count_t'(rd_offset) + 1'b1) < read_count);

  assign next_offset = advance ? rd_offset + 1'b1 : rd_offset;

  // Next address goes out now so the RAM register holds it next cycle
  assign ram_read_address = {rd_bank, next_offset};

  assign read_ready = (state == RD_OFFER);

  assign handoff.grant_taken   = (state == RD_IDLE) && handoff.grant_valid;
  assign handoff.bank_released = (state == RD_RELEASE) ?
                                 (bank_mask_t'(1) << rd_bank) : '0;

  always_ff @(posedge write_clock) begin
    if (reset) begin
      state      <= RD_IDLE;
      rd_bank    <= 1'b0;
      rd_offset  <= '0;
      read_count <= '0;
    end else begin
      rd_offset <= next_offset;
      case (state)
        RD_IDLE:
          if (handoff.grant_taken) begin
            rd_bank    <= handoff.grant_bank;
            read_count <= handoff.bank_count[handoff.grant_bank];
            rd_offset  <= '0;
            state      <= RD_PREFETCH;
          end
        // Word 0 address is out, RAM output settles this cycle
        RD_PREFETCH:
          state <= RD_OFFER;
        RD_OFFER:
          if (read_activate)
            state <= RD_ACTIVE;
        RD_ACTIVE:
          if (!read_activate)
            state <= RD_RELEASE;
        // bank_released is high for this one cycle
        RD_RELEASE: begin
          read_count <= '0;
          state      <= RD_IDLE;
        end
        default:
          state <= RD_IDLE;
      endcase
    end
  end

  assert property (@(posedge write_clock) disable iff (reset)
    read_strobe |-> read_activate);

endmodule

//--- ppfifo/ppfifo_buffer_ram.sv
/* Both banks in one simple dual-port memory, bank index in the address MSB.
   Read data is registered; contents are not cleared by reset. */
module ppfifo_buffer_ram #(
  parameter int DATA_WIDTH    = 8,
  parameter int ADDRESS_WIDTH = 4
) (
  input  logic                   write_clock,
  input  logic                   write_enable,
  input  logic [ADDRESS_WIDTH:0] write_address,
  input  logic [DATA_WIDTH-1:0]  write_data,
  input  logic [ADDRESS_WIDTH:0] read_address,
  output logic [DATA_WIDTH-1:0]  read_data
);

  // Two banks of 2**ADDRESS_WIDTH words
  logic [DATA_WIDTH-1:0] mem [2 << ADDRESS_WIDTH];

  always_ff @(posedge write_clock) begin
    if (write_enable)
      mem[write_address] <= write_data;
    read_data <= mem[read_address];
  end

endmodule

//--- verilog/ppfifo.sv
/* Ping-pong packet FIFO with two banks on a single clock.
   write_activate must be one-hot or zero; bank depth is 2**ADDRESS_WIDTH words. */
module ppfifo #(
  parameter int DATA_WIDTH    = ppfifo_pkg::DEFAULT_DATA_WIDTH,
  parameter int ADDRESS_WIDTH = ppfifo_pkg::DEFAULT_ADDRESS_WIDTH
) (
  input  logic                               write_clock,
  input  logic                               reset,
  input  logic [1:0]                         write_activate,
  output logic [1:0]                         write_ready,
  input  logic                               write_strobe,
  input  logic [DATA_WIDTH-1:0]              write_data,
  input  logic                               read_activate,
  input  logic                               read_strobe,
  output logic                               read_ready,
  output logic [ppfifo_pkg::COUNT_WIDTH-1:0] read_count,
  output logic [DATA_WIDTH-1:0]              read_data,
  output logic                               inactive
);

  logic                   ram_write_enable;
  logic [ADDRESS_WIDTH:0] ram_write_address;
  logic [ADDRESS_WIDTH:0] ram_read_address;

  bank_handoff_if handoff (.write_clock(write_clock));

  ppfifo_write_ctrl #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH)
  ) write_ctrl0 (
    .write_clock       (write_clock),
    .reset             (reset),
    .write_activate    (write_activate),
    .write_strobe      (write_strobe),
    .write_ready       (write_ready),
    .inactive          (inactive),
    .ram_write_enable  (ram_write_enable),
    .ram_write_address (ram_write_address),
    .handoff           (handoff.write_side)
  );

  bank_arbiter arbiter0 (
    .write_clock (write_clock),
    .reset       (reset),
    .handoff     (handoff.arbiter)
  );

  ppfifo_read_ctrl #(
    .DATA_WIDTH    (DATA_WIDTH),
    .ADDRESS_WIDTH (ADDRESS_WIDTH)
  ) read_ctrl0 (
    .write_clock      (write_clock),
    .reset            (reset),
    .read_activate    (read_activate),
    .read_strobe      (read_strobe),
    .read_ready       (read_ready),
    .read_count       (read_count),
    .ram_read_address (ram_read_address),
    .handoff          (handoff.read_side)
  );

  // RAM output is the user read data directly
  ppfifo_buffer_ram #(
    .DATA_WIDTH    (DATA_WIDTH),
    .ADDRESS_WIDTH (ADDRESS_WIDTH)
  ) ram0 (
    .write_clock   (write_clock),
    .write_enable  (ram_write_enable),
    .write_address (ram_write_address),
    .write_data    (write_data),
    .read_address  (ram_read_address),
    .read_data     (read_data)
  );

endmodule

//--- tests/ppfifo_tb.sv
/* Random packet test for the ping-pong FIFO at default parameters, depth 16.
   Stops at the first failed check; the cycle limit assumes about 40 packets. */
module ppfifo_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH = 16;
  localparam int NUM_RANDOM = 36;
  // About 40 packets of at most 80 cycles each
  localparam int TIMEOUT_CYCLES = 4000;

  logic        write_clock;
  logic        reset;
  logic [1:0]  write_activate;
  logic [1:0]  write_ready;
  logic        write_strobe;
  logic [7:0]  write_data;
  logic        read_activate;
  logic        read_strobe;
  logic        read_ready;
  logic [23:0] read_count;
  logic [7:0]  read_data;
  logic        inactive;

  // Scoreboard holding the words of all packets back to back in write order
  logic [7:0]  sb_words[$];
  int          sb_len[$];
  logic        sb_bank[$];
  // Packets written and not yet read
  int          pending;
  int          cycle_count = 0;
  logic        next_bank;

  // Expected read side values, updated along with the stimulus
  logic [23:0] exp_count;
  logic [7:0]  exp_data;
  logic        check_data;
  // Expected values above belong to the next offered packet
  logic        expect_offer;

  ppfifo dut0 (
    .write_clock    (write_clock),
    .reset          (reset),
    .write_activate (write_activate),
    .write_ready    (write_ready),
    .write_strobe   (write_strobe),
    .write_data     (write_data),
    .read_activate  (read_activate),
    .read_strobe    (read_strobe),
    .read_ready     (read_ready),
    .read_count     (read_count),
    .read_data      (read_data),
    .inactive       (inactive)
  );

  always #4 write_clock = ~write_clock;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("mismatch %s expected %0h actual %0h", name, expected, actual);
    $display("ERRORS FOUND");
    $fatal(1, "check %s failed", name);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "%s", what);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge write_clock);
    #1;
  endtask

  task automatic write_packet(input int len);
    logic       bank;
    logic [7:0] d;
    bank = next_bank;
    next_bank = ~next_bank;
    while (!write_ready[bank])
      next_cycle();
    write_activate = 2'b01 << bank;
    for (int i = 0; i < len; i++) begin
      d = 8'($urandom);
      write_strobe = 1'b1;
      write_data = d;
      // Words past the depth are dropped
      if (i < DEPTH)
        sb_words.push_back(d);
      next_cycle();
    end
    write_strobe = 1'b0;
    write_activate = 2'b00;
    sb_len.push_back(len < DEPTH ? len : DEPTH);
    sb_bank.push_back(bank);
    pending++;
    // Activate must rest at zero for a cycle between banks
    next_cycle();
  endtask

  task automatic read_packet();
    logic [7:0] words[DEPTH];
    int         n;
    int         idx;
    int         extra;
    logic       bank;
    logic       strobe;
    while (pending == 0)
      next_cycle();
    n = sb_len[0];
    bank = sb_bank[0];
    for (int i = 0; i < n; i++)
      words[i] = sb_words[i];
    // Oldest packet is offered first, word 0 falls through
    exp_count = 24'(n);
    exp_data = words[0];
    expect_offer = 1'b1;
    while (!read_ready)
      next_cycle();
    read_activate = 1'b1;
    check_data = 1'b1;
    next_cycle();
    assert (!read_ready) else report_failure("read_ready stayed high after read_activate");
    idx = 0;
    // Two strobes past the last word
    extra = 2;
    while (idx < n - 1 || extra > 0) begin
      if (idx < n - 1) begin
        strobe = ($urandom_range(3, 0) != 0);
      end else begin
        strobe = 1'b1;
        extra--;
      end
      read_strobe = strobe;
      next_cycle();
      // Next word shows from the cycle after the strobe, last word holds
      if (strobe && idx < n - 1)
        idx++;
      exp_data = words[idx];
    end
    read_strobe = 1'b0;
    read_activate = 1'b0;
    check_data = 1'b0;
    expect_offer = 1'b0;
    next_cycle();
    assert (!write_ready[bank])
      else report_mismatch("release_early", 32'(0), 32'(write_ready[bank]));
    // Bank is back with the writer two cycles after read_activate falls
    next_cycle();
    assert (write_ready[bank])
      else report_mismatch("release", 32'(1), 32'(write_ready[bank]));
    repeat (n) void'(sb_words.pop_front());
    void'(sb_len.pop_front());
    void'(sb_bank.pop_front());
    pending--;
  endtask

  // Activation without strobes keeps the bank free
  task automatic activate_empty(input logic bank);
    while (!write_ready[bank])
      next_cycle();
    write_activate = 2'b01 << bank;
    repeat (3) next_cycle();
    write_activate = 2'b00;
    repeat (2) next_cycle();
    assert (write_ready[bank])
      else report_mismatch("empty_activation", 32'(1), 32'(write_ready[bank]));
  endtask

  // Offered bank shows its length
  assert property (@(posedge write_clock) disable iff (reset)
    (read_ready && expect_offer) |-> read_count == exp_count)
    else report_mismatch("read_count", 32'($sampled(exp_count)), 32'($sampled(read_count)));

  // Word 0 while offered, then the current word while reading
  assert property (@(posedge write_clock) disable iff (reset)
    ((read_ready && expect_offer) || check_data) |-> read_data == exp_data)
    else report_mismatch("read_data", 32'($sampled(exp_data)), 32'($sampled(read_data)));

  assert property (@(posedge write_clock) disable iff (reset)
    read_ready |-> pending > 0)
    else report_failure("read_ready rose with no packet written");

  always @(posedge write_clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      report_failure("timeout, the run did not finish within the cycle limit");
  end

  initial begin
    write_clock = 1'b0;
    reset = 1'b1;
    write_activate = 2'b00;
    write_strobe = 1'b0;
    write_data = 8'h00;
    read_activate = 1'b0;
    read_strobe = 1'b0;
    exp_count = '0;
    exp_data = '0;
    check_data = 1'b0;
    expect_offer = 1'b0;
    pending = 0;
    next_bank = 1'b0;
    void'($urandom(86));

    // Reset held three cycles
    repeat (3) begin
      next_cycle();
      assert (write_ready == 2'b00 && !read_ready)
        else report_mismatch("reset", 32'(0), 32'({write_ready, read_ready}));
    end
    reset = 1'b0;
    next_cycle();
    assert (write_ready == 2'b00)
      else report_mismatch("reset_release", 32'(0), 32'(write_ready));
    next_cycle();
    assert (write_ready == 2'b11)
      else report_mismatch("reset_ready", 32'(3), 32'(write_ready));
    assert (inactive) else report_mismatch("reset_inactive", 32'(1), 32'(inactive));

    // Single round trip
    write_packet($urandom_range(DEPTH, 1));
    read_packet();

    // Both banks filled before reading
    write_packet($urandom_range(DEPTH, 1));
    write_packet($urandom_range(DEPTH, 1));
    assert (write_ready == 2'b00)
      else report_mismatch("both_full", 32'(0), 32'(write_ready));
    assert (!inactive) else report_mismatch("both_full_inactive", 32'(0), 32'(inactive));
    read_packet();
    read_packet();

    // Overfill saturates at depth
    write_packet(DEPTH + 4);
    read_packet();

    activate_empty(1'b0);
    activate_empty(1'b1);

    // Writer and reader running together
    fork
      begin
        for (int k = 0; k < NUM_RANDOM; k++) begin
          repeat ($urandom_range(3, 0)) next_cycle();
          write_packet($urandom_range(DEPTH, 1));
        end
      end
      begin
        repeat (NUM_RANDOM) read_packet();
      end
    join

    next_cycle();
    assert (write_ready == 2'b11)
      else report_mismatch("final_ready", 32'(3), 32'(write_ready));
    assert (inactive) else report_mismatch("final_inactive", 32'(1), 32'(inactive));

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- ppfifo.f
common/ppfifo_pkg.sv
common/bank_handoff_if.sv
ppfifo/ppfifo_write_ctrl.sv
ppfifo/bank_arbiter.sv
ppfifo/ppfifo_read_ctrl.sv
ppfifo/ppfifo_buffer_ram.sv
verilog/ppfifo.sv
tests/ppfifo_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
# Exit status is nonzero when the simulation fails
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f ppfifo.f \
  --top-module ppfifo_tb \
  -o ppfifo_tb_sim

./obj_dir/ppfifo_tb_sim
